// ==== all.f ====
hdl/panel_pkg.sv
hdl/button_debouncer.sv
hdl/front_panel.sv
hdl/word_ram.sv
hdl/io_regs.sv
hdl/sevenseg_driver.sv
hdl/panel_top.sv
testbench/panel_tb.sv

// ==== hdl/button_debouncer.sv ====
`timescale 1ns/1ps

module button_debouncer import panel_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic btn,
    output logic press_pulse,
    output logic short_pulse,
    output logic long_pulse
);

    logic                  sync0;
    logic                  sync1;       // Synchronized button level
    logic                  state;       // Accepted (debounced) level
    logic [DB_CNT_W-1:0]   db_cnt;      // Cycles the new level has been stable
    logic [LONG_CNT_W-1:0] hold_cnt;    // Cycles held since press accepted
    logic                  long_done;   // Long gesture already reported
    logic                  long_hit;

    // Hold reaches the long threshold this cycle
    assign long_hit = state && !long_done && (hold_cnt == LONG_CNT_W'(LONG_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            sync0       <= 1'b0;
            sync1       <= 1'b0;
            state       <= 1'b0;
            db_cnt      <= '0;
            hold_cnt    <= '0;
            long_done   <= 1'b0;
            press_pulse <= 1'b0;
            short_pulse <= 1'b0;
            long_pulse  <= 1'b0;
        end else begin
            sync0       <= btn;
            sync1       <= sync0;
            press_pulse <= 1'b0;
            short_pulse <= 1'b0;
            long_pulse  <= 1'b0;

            if (sync1 == state) begin
                db_cnt <= '0;                       // Bounce back, start over
            end else if (db_cnt == DB_CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                db_cnt <= '0;
                state  <= sync1;                    // Change accepted
                if (sync1) begin
                    press_pulse <= 1'b1;
                    hold_cnt    <= '0;
                    long_done   <= 1'b0;
                end else if (!long_done && !long_hit) begin
                    short_pulse <= 1'b1;            // Released before long threshold
                end
            end else begin
                db_cnt <= db_cnt + 1'b1;
            end

            // Hold timer, runs once per press
            if (long_hit) begin
                long_pulse <= 1'b1;
                long_done  <= 1'b1;
            end else if (state && !long_done) begin
                hold_cnt <= hold_cnt + 1'b1;
            end
        end
    end

    // One gesture per press
    a_gesture_excl: assert property (@(posedge clk) disable iff (reset)
        !(short_pulse && long_pulse));

endmodule

// ==== hdl/front_panel.sv ====
`timescale 1ns/1ps

module front_panel import panel_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  word_t    sw,
    input  logic     l_short,
    input  logic     l_long,
    input  logic     u_press,
    input  logic     d_press,
    input  word_t    imem_rdata,
    input  word_t    dmem_rdata,
    input  word_t    io_rdata,
    input  word_t    led_reg,
    output mem_req_t mem_req,
    output word_t    led,
    output display_t disp
);

    panel_mode_t mode;
    panel_op_t   op;
    logic        sel_imem;    // 1 selects IMEM, 0 selects DMEM and I/O
    word_t       addr;        // Panel address
    word_t       data;        // Last examined or deposited word
    logic        to_imem;
    logic        to_dmem;
    logic        to_io;
    word_t       src_rdata;

    // Target decode, IMEM wins when selected
    assign to_imem = sel_imem;
    assign to_dmem = !sel_imem && !addr[IO_SEL_BIT];
    assign to_io   = !sel_imem && addr[IO_SEL_BIT];

    always_comb begin
        if (to_imem) begin
            src_rdata = imem_rdata;
        end else if (to_dmem) begin
            src_rdata = dmem_rdata;
        end else begin
            src_rdata = io_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mode     <= MODE_NORMAL;
            sel_imem <= 1'b0;
            op       <= OP_IDLE;
            addr     <= '0;
            data     <= '0;
        end else begin
            // Mode control
            case (mode)
                MODE_NORMAL: begin
                    if (l_short) begin
                        mode     <= MODE_PANEL;
                        sel_imem <= 1'b0;           // Always start on DMEM
                    end
                end
                MODE_PANEL: begin
                    if (l_long) begin
                        mode <= MODE_NORMAL;
                    end
                end
            endcase

            // Examine/deposit sequencer
            case (op)
                OP_IDLE: begin
                    if (mode == MODE_PANEL) begin
                        if (u_press) begin
                            addr <= sw;             // Examine address from switches
                            op   <= OP_READ_WAIT;
                        end else if (d_press) begin
                            op <= OP_WRITE;
                        end else if (l_short) begin
                            sel_imem <= ~sel_imem;
                        end
                    end
                end
                OP_READ_WAIT: begin
                    op <= sel_imem ? OP_READ_WAIT2 : OP_READ_DONE;
                end
                OP_READ_WAIT2: op <= OP_READ_DONE;
                OP_READ_DONE: begin
                    data <= src_rdata;
                    op   <= OP_IDLE;
                end
                OP_WRITE: begin
                    data <= sw;                     // Echo the deposited word
                    op   <= OP_WRITE_DONE;
                end
                OP_WRITE_DONE: begin
                    addr <= addr + 1'b1;            // Auto advance for next deposit
                    op   <= OP_IDLE;
                end
                default: op <= OP_IDLE;
            endcase
        end
    end

    // Request bus, strobes only in the write state
    always_comb begin
        mem_req.addr    = addr;
        mem_req.wdata   = sw;
        mem_req.imem_we = (op == OP_WRITE) && to_imem;
        mem_req.dmem_we = (op == OP_WRITE) && to_dmem;
        mem_req.io_wr   = (op == OP_WRITE) && to_io;
    end

    always_comb begin
        if (mode == MODE_PANEL) begin
            led        = data;
            disp.value = addr;
            disp.dots  = {sel_imem, ~sel_imem, 2'b00};   // Selection dots
        end else begin
            led        = led_reg;
            disp.value = led_reg;
            disp.dots  = 4'b0000;
        end
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (reset)
        $onehot0({mem_req.imem_we, mem_req.dmem_we, mem_req.io_wr}));

endmodule

// ==== hdl/io_regs.sv ====
`timescale 1ns/1ps

module io_regs import panel_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  word_t addr,
    input  word_t wdata,
    input  logic  wr,
    input  word_t sw,
    output word_t rdata,
    output word_t led_reg
);

    // LED register write
    always_ff @(posedge clk) begin
        if (reset) begin
            led_reg <= '0;
        end else if (wr && addr == IO_LED_ADDR) begin
            led_reg <= wdata;
        end
    end

    // Readback follows the address, one cycle late
    always_ff @(posedge clk) begin
        case (addr)
            IO_LED_ADDR: rdata <= led_reg;
            IO_SW_ADDR:  rdata <= sw;      // Live switch value
            default:     rdata <= '0;      // Unmapped I/O reads zero
        endcase
    end

endmodule

// ==== hdl/panel_pkg.sv ====
package panel_pkg;

    // Word and address map
    localparam int WORD_W      = 16;
    localparam int IMEM_ADDR_W = 14;     // 16K instruction words
    localparam int DMEM_ADDR_W = 15;     // 32K data words
    localparam int IO_SEL_BIT  = 15;     // Set means I/O on the data side

    typedef logic [WORD_W-1:0] word_t;

    localparam word_t IO_LED_ADDR = 16'h8000;
    localparam word_t IO_SW_ADDR  = 16'h8001;

    // Short timings so simulation stays quick
    localparam int DEBOUNCE_CYCLES = 16;
    localparam int LONG_CYCLES     = 256;
    localparam int SCAN_CYCLES     = 8;

    localparam int DB_CNT_W   = $clog2(DEBOUNCE_CYCLES);
    localparam int LONG_CNT_W = $clog2(LONG_CYCLES);
    localparam int SCAN_CNT_W = $clog2(SCAN_CYCLES);

    typedef enum logic {
        MODE_NORMAL,
        MODE_PANEL
    } panel_mode_t;

    typedef enum logic [2:0] {
        OP_IDLE,
        OP_READ_WAIT,
        OP_READ_WAIT2,    // IMEM only, covers its output register
        OP_READ_DONE,
        OP_WRITE,
        OP_WRITE_DONE
    } panel_op_t;

    // Panel access request, strobes are one cycle wide
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  imem_we;
        logic  dmem_we;
        logic  io_wr;
    } mem_req_t;

    typedef struct packed {
        word_t      value;
        logic [3:0] dots;    // Dot 3 is leftmost
    } display_t;

endpackage

// ==== hdl/panel_top.sv ====
`timescale 1ns/1ps

module panel_top import panel_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       btn_l,
    input  logic       btn_u,
    input  logic       btn_d,
    input  word_t      sw,
    output word_t      led,
    output logic [6:0] seg,
    output logic       dp,
    output logic [3:0] an
);

    logic                   l_short;
    logic                   l_long;
    logic                   u_press;
    logic                   d_press;
    mem_req_t               mem_req;    // Panel request, shared by all targets
    word_t                  imem_rdata;
    word_t                  dmem_rdata;
    word_t                  io_rdata;
    word_t                  led_reg;
    display_t               disp;
    logic [IMEM_ADDR_W-1:0] imem_addr;
    logic [DMEM_ADDR_W-1:0] dmem_addr;

    // RAMs see only their low address bits
    assign imem_addr = mem_req.addr[IMEM_ADDR_W-1:0];
    assign dmem_addr = mem_req.addr[DMEM_ADDR_W-1:0];

    // Left button, short and long gestures
    button_debouncer btn_l0 (
        .clk         (clk),
        .reset       (reset),
        .btn         (btn_l),
        .press_pulse (),
        .short_pulse (l_short),
        .long_pulse  (l_long)
    );

    button_debouncer btn_u0 (      // Examine
        .clk         (clk),
        .reset       (reset),
        .btn         (btn_u),
        .press_pulse (u_press),
        .short_pulse (),
        .long_pulse  ()
    );

    button_debouncer btn_d0 (      // Deposit
        .clk         (clk),
        .reset       (reset),
        .btn         (btn_d),
        .press_pulse (d_press),
        .short_pulse (),
        .long_pulse  ()
    );

    front_panel panel0 (
        .clk        (clk),
        .reset      (reset),
        .sw         (sw),
        .l_short    (l_short),
        .l_long     (l_long),
        .u_press    (u_press),
        .d_press    (d_press),
        .imem_rdata (imem_rdata),
        .dmem_rdata (dmem_rdata),
        .io_rdata   (io_rdata),
        .led_reg    (led_reg),
        .mem_req    (mem_req),
        .led        (led),
        .disp       (disp)
    );

    // IMEM has the output register, hence the extra wait state
    word_ram #(.ADDR_W(IMEM_ADDR_W), .OUT_REG(1'b1)) imem0 (
        .clk   (clk),
        .we    (mem_req.imem_we),
        .waddr (imem_addr),
        .raddr (imem_addr),
        .wdata (mem_req.wdata),
        .rdata (imem_rdata)
    );

    word_ram #(.ADDR_W(DMEM_ADDR_W), .OUT_REG(1'b0)) dmem0 (
        .clk   (clk),
        .we    (mem_req.dmem_we),
        .waddr (dmem_addr),
        .raddr (dmem_addr),
        .wdata (mem_req.wdata),
        .rdata (dmem_rdata)
    );

    io_regs io0 (
        .clk     (clk),
        .reset   (reset),
        .addr    (mem_req.addr),
        .wdata   (mem_req.wdata),
        .wr      (mem_req.io_wr),
        .sw      (sw),
        .rdata   (io_rdata),
        .led_reg (led_reg)
    );

    sevenseg_driver seg0 (
        .clk   (clk),
        .reset (reset),
        .disp  (disp),
        .an    (an),
        .seg   (seg),
        .dp    (dp)
    );

endmodule

// ==== hdl/sevenseg_driver.sv ====
`timescale 1ns/1ps

module sevenseg_driver import panel_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  display_t   disp,
    output logic [3:0] an,
    output logic [6:0] seg,
    output logic       dp
);

    logic [SCAN_CNT_W-1:0] scan_cnt;    // Dwell time per digit
    logic [1:0]            digit;       // 0 is rightmost
    logic [3:0]            nibble;

    assign nibble = disp.value[digit*4 +: 4];

    // Hex to segments, active low, seg[0] is a
    function automatic logic [6:0] hex_to_seg(input logic [3:0] h);
        case (h)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'hA: return 7'h08;
            4'hB: return 7'h03;
            4'hC: return 7'h46;
            4'hD: return 7'h21;
            4'hE: return 7'h06;
            default: return 7'h0E;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            scan_cnt <= '0;
            digit    <= 2'd0;
            an       <= 4'b1111;    // Blank during reset
            seg      <= 7'h7F;
            dp       <= 1'b1;
        end else begin
            if (scan_cnt == SCAN_CNT_W'(SCAN_CYCLES - 1)) begin
                scan_cnt <= '0;
                digit    <= digit + 1'b1;
            end else begin
                scan_cnt <= scan_cnt + 1'b1;
            end
            an  <= ~(4'b0001 << digit);    // One anode low
            seg <= hex_to_seg(nibble);
            dp  <= ~disp.dots[digit];
        end
    end

endmodule

// ==== hdl/word_ram.sv ====
`timescale 1ns/1ps

module word_ram #(
    parameter int ADDR_W  = 14,
    parameter bit OUT_REG = 1'b0
) (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [ADDR_W-1:0] raddr,
    input  logic [15:0]       wdata,
    output logic [15:0]       rdata
);

    logic [15:0] mem [2**ADDR_W];
    logic [15:0] rd_q;    // Array read stage

    initial begin
        for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) mem[waddr] <= wdata;
        rd_q <= mem[raddr];    // Old data on same-address write
    end

    generate
        if (OUT_REG) begin : g_out_reg
            logic [15:0] out_q;    // Second stage, two-cycle read
            always_ff @(posedge clk) out_q <= rd_q;
            assign rdata = out_q;
        end else begin : g_no_reg
            assign rdata = rd_q;
        end
    endgenerate

    a_waddr_known: assert property (@(posedge clk) we |-> !$isunknown(waddr));

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the panel testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module panel_tb \
    -Mdir obj_dir -o panel_sim || exit 1
out=$(./obj_dir/panel_sim)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS" && echo "run.sh: simulation passed" || {
    echo "run.sh: simulation failed"
    exit 1
}

// ==== testbench/panel_tb.sv ====
`timescale 1ns/1ps

module panel_tb import panel_pkg::*; ();

    localparam logic [2:0] BTN_L = 3'b100;    // Masks for {btn_l, btn_u, btn_d}
    localparam logic [2:0] BTN_U = 3'b010;
    localparam logic [2:0] BTN_D = 3'b001;
    localparam int SHORT_HOLD  = 3 * DEBOUNCE_CYCLES;            // Well below the long threshold
    localparam int LONG_HOLD   = LONG_CYCLES + 4 * DEBOUNCE_CYCLES;
    localparam int GLITCH_HOLD = DEBOUNCE_CYCLES / 2;            // Never accepted
    localparam int SETTLE      = 2 * DEBOUNCE_CYCLES;            // Release debounce
    localparam int WAIT_LIMIT  = 200;
    localparam int SCAN_LIMIT  = 8 * SCAN_CYCLES;

    logic       clk;
    logic       reset;
    logic       btn_l;
    logic       btn_u;
    logic       btn_d;
    word_t      sw;
    word_t      led;
    logic [6:0] seg;
    logic       dp;
    logic [3:0] an;

    word_t imem_model [2**IMEM_ADDR_W];    // Reference memories
    word_t dmem_model [2**DMEM_ADDR_W];
    word_t led_model;
    logic  sel_model;                      // 1 while IMEM is selected
    word_t cur_addr;                       // Panel address
    word_t shown;                          // Word expected on led in panel mode
    word_t addr_q [$];                     // Deposited DMEM addresses
    int    seed = 32'h5e14_6248;
    int    errors;
    int    test_errors;
    int    tests_run;
    int    tests_failed;

    panel_top dut0 (.clk(clk), .reset(reset), .btn_l(btn_l), .btn_u(btn_u), .btn_d(btn_d),
                    .sw(sw), .led(led), .seg(seg), .dp(dp), .an(an));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Expected examine result, IMEM first, then DMEM, then I/O
    function automatic word_t expected_read(input logic imem_sel, input word_t a, input word_t s);
        if (imem_sel) return imem_model[a[IMEM_ADDR_W-1:0]];
        if (!a[IO_SEL_BIT]) return dmem_model[a[DMEM_ADDR_W-1:0]];
        if (a == IO_LED_ADDR) return led_model;
        if (a == IO_SW_ADDR) return s;         // Live switches
        return '0;
    endfunction

    function automatic void model_write(input word_t a, input word_t d);
        if (sel_model) imem_model[a[IMEM_ADDR_W-1:0]] = d;
        else if (!a[IO_SEL_BIT]) dmem_model[a[DMEM_ADDR_W-1:0]] = d;
        else if (a == IO_LED_ADDR) led_model = d;    // Other I/O writes are lost
    endfunction

    // Lit segments as {g,f,e,d,c,b,a}
    function automatic logic [6:0] lit_segments(input logic [3:0] h);
        case (h)
            4'h0: return 7'b0111111;
            4'h1: return 7'b0000110;
            4'h2: return 7'b1011011;
            4'h3: return 7'b1001111;
            4'h4: return 7'b1100110;
            4'h5: return 7'b1101101;
            4'h6: return 7'b1111101;
            4'h7: return 7'b0000111;
            4'h8: return 7'b1111111;
            4'h9: return 7'b1101111;
            4'hA: return 7'b1110111;
            4'hB: return 7'b1111100;
            4'hC: return 7'b0111001;
            4'hD: return 7'b1011110;
            4'hE: return 7'b1111001;
            default: return 7'b1110001;
        endcase
    endfunction

    function automatic logic [3:0] sel_dots();
        return {sel_model, ~sel_model, 2'b00};    // Dot 3 IMEM, dot 2 DMEM
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic press_button(input logic [2:0] mask, input int hold);
        @(posedge clk);
        {btn_l, btn_u, btn_d} <= mask;
        repeat (hold) @(posedge clk);
        {btn_l, btn_u, btn_d} <= 3'b000;
        repeat (SETTLE) @(posedge clk);
    endtask

    task automatic wait_led(input string name, input word_t exp);
        int n;
        n = 0;
        @(negedge clk);
        while (led !== exp && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (led !== exp) $display("%s: led never reached the expected word in time", name);
        check(name, 32'(exp), 32'(led));
    endtask

    // Walk the scan until every digit has been lit once
    task automatic check_display(input string name, input word_t value, input logic [3:0] dots);
        logic [3:0] seen;
        logic [6:0] exp_seg;    // Active low pattern of the lit digit
        logic       exp_dp;
        int         k;
        int         n;
        seen = 4'b0000;
        n = 0;
        while (seen != 4'b1111 && n < SCAN_LIMIT) begin
            @(negedge clk);
            n++;
            case (an)
                4'b1110: k = 0;
                4'b1101: k = 1;
                4'b1011: k = 2;
                4'b0111: k = 3;
                default: k = -1;    // Blank
            endcase
            if (k >= 0 && !seen[k]) begin
                seen[k] = 1'b1;
                exp_seg = ~lit_segments(value[k*4 +: 4]);
                exp_dp  = ~dots[k];
                check($sformatf("%s digit %0d seg", name, k), 32'(exp_seg), 32'(seg));
                check($sformatf("%s digit %0d dp", name, k), 32'(exp_dp), 32'(dp));
            end
        end
        if (seen != 4'b1111) begin
            $display("%s: display scan stalled, not every digit was lit", name);
            errors++;
        end
    endtask

    task automatic examine(input string name, input word_t a);
        @(posedge clk);
        sw <= a;
        press_button(BTN_U, SHORT_HOLD);
        cur_addr = a;
        shown = expected_read(sel_model, a, a);
        wait_led(name, shown);
    endtask

    task automatic deposit(input string name, input word_t d);
        @(posedge clk);
        sw <= d;
        press_button(BTN_D, SHORT_HOLD);
        model_write(cur_addr, d);
        shown = d;                              // Echo of the written word
        wait_led(name, d);
        cur_addr = cur_addr + 1'b1;             // Auto advance
        check_display(name, cur_addr, sel_dots());
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d failed checks", name, errors - test_errors);
            tests_failed++;
        end
        test_errors = errors;
    endtask

    initial begin : main
        word_t base;
        reset <= 1'b1;
        {btn_l, btn_u, btn_d} <= 3'b000;
        sw <= '0;
        foreach (imem_model[i]) imem_model[i] = '0;    // RAMs start zeroed
        foreach (dmem_model[i]) dmem_model[i] = '0;
        led_model = '0;
        sel_model = 1'b0;
        cur_addr = '0;
        shown = '0;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        check("reset led", 32'h0, 32'(led));
        check_display("reset display", 16'h0000, 4'b0000);
        finish_test("reset state");

        press_button(BTN_L, SHORT_HOLD);        // Enter panel mode on DMEM
        check_display("panel entry", cur_addr, sel_dots());
        for (int i = 0; i < 4; i++) begin
            base = word_t'($random(seed)) & 16'h7ff8;    // Room for three words
            examine("dmem examine", base);
            for (int j = 0; j < 3; j++) begin
                addr_q.push_back(cur_addr);
                deposit("dmem deposit", word_t'($random(seed)));
            end
        end
        foreach (addr_q[i]) examine("dmem readback", addr_q[i]);
        finish_test("dmem deposit and examine");

        press_button(BTN_L, SHORT_HOLD);
        sel_model = 1'b1;
        check_display("imem select dots", cur_addr, sel_dots());
        foreach (addr_q[i]) begin
            examine("imem examine", addr_q[i]);
            deposit("imem deposit", word_t'($random(seed)));
        end
        foreach (addr_q[i]) examine("imem readback", addr_q[i]);
        press_button(BTN_L, SHORT_HOLD);
        sel_model = 1'b0;
        check_display("dmem select dots", cur_addr, sel_dots());
        foreach (addr_q[i]) examine("dmem kept", addr_q[i]);
        finish_test("separate memories");

        examine("unmapped io", 16'hbeef);
        check_display("address digits", 16'hbeef, sel_dots());
        base = word_t'($random(seed));
        examine("random examine", base);
        check_display("address digits", base, sel_dots());
        finish_test("display digits");

        @(posedge clk);
        sw <= 16'h0123;
        press_button(BTN_L, GLITCH_HOLD);
        press_button(BTN_U, GLITCH_HOLD);
        press_button(BTN_D, GLITCH_HOLD);
        @(negedge clk);
        check("glitch led", 32'(shown), 32'(led));
        check_display("glitch display", cur_addr, sel_dots());   // Mode shows in dots
        finish_test("short glitches");

        examine("examine led reg", IO_LED_ADDR);
        deposit("deposit led reg", word_t'($random(seed)));
        examine("led reg readback", IO_LED_ADDR);
        examine("examine switches", IO_SW_ADDR);
        press_button(BTN_L, LONG_HOLD);         // Back to normal mode
        wait_led("normal led", led_model);
        check_display("normal display", led_model, 4'b0000);
        finish_test("io and normal mode");

        $display("tests run %0d, failed %0d, failed checks %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
